// File: hdl/hdc_pkg.sv
package hdc_pkg;

    // axi4-lite word and item index lane
    localparam int word_w = 32;
    // output stream beat
    localparam int out_w = 64;

    // register byte offsets
    localparam logic [31:0] reg_ctrl     = 32'h0000_0000;
    localparam logic [31:0] reg_item_num = 32'h0000_0004;

    // generator state whenever gen is low
    localparam logic [31:0] xorshift_seed = 32'd2463534242;

    typedef enum logic [2:0] {
        axil_idle,
        axil_addr_only,
        axil_data_only,
        axil_write_resp,
        axil_read_fetch,
        axil_read_resp
    } axil_state_t;

    typedef enum logic [1:0] {
        frame_accept,
        frame_drain,
        frame_capture,
        frame_send
    } frame_state_t;

endpackage

// File: hdl/axil_regs.sv
module axil_regs (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic [31:0]                 s_axi_awaddr,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [hdc_pkg::word_w-1:0]  s_axi_wdata,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic                        s_axi_bvalid,
    output logic [1:0]                  s_axi_bresp,
    input  logic                        s_axi_bready,
    input  logic [31:0]                 s_axi_araddr,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic                        s_axi_rvalid,
    output logic [hdc_pkg::word_w-1:0]  s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    input  logic                        s_axi_rready,
    input  logic                        gen_done,
    output logic                        run,
    output logic                        gen,
    output logic [15:0]                 item_num
);
    import hdc_pkg::*;

    axil_state_t       state;
    logic [31:0]       wr_addr;
    logic [31:0]       rd_addr;
    logic [word_w-1:0] wr_data;
    logic              wr_en;

    assign s_axi_awready = (state == axil_idle) || (state == axil_data_only);
    assign s_axi_wready  = (state == axil_idle) || (state == axil_addr_only);
    // a write on offer wins over a read in idle
    assign s_axi_arready = (state == axil_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = state == axil_write_resp;
    assign s_axi_rvalid  = state == axil_read_resp;
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    // register update on the b handshake
    assign wr_en = (state == axil_write_resp) && s_axi_bready;

    // ======================================================================
    // slave fsm
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= axil_idle;
        end else begin
            case (state)
                axil_idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= axil_write_resp;
                    end else if (s_axi_awvalid) begin
                        state <= axil_addr_only;
                    end else if (s_axi_wvalid) begin
                        state <= axil_data_only;
                    end else if (s_axi_arvalid) begin
                        state <= axil_read_fetch;
                    end
                end
                axil_addr_only: begin
                    if (s_axi_wvalid) begin
                        state <= axil_write_resp;
                    end
                end
                axil_data_only: begin
                    if (s_axi_awvalid) begin
                        state <= axil_write_resp;
                    end
                end
                axil_write_resp: begin
                    if (s_axi_bready) begin
                        state <= axil_idle;
                    end
                end
                axil_read_fetch: state <= axil_read_resp;
                axil_read_resp: begin
                    if (s_axi_rready) begin
                        state <= axil_idle;
                    end
                end
                default: state <= axil_idle;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr;
        end
    end

    // ======================================================================
    // control and size registers
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run      <= 1'b0;
            gen      <= 1'b0;
            item_num <= '0;
        end else begin
            if (wr_en && wr_addr == reg_ctrl) begin
                {run, gen} <= wr_data[1:0];
            end else if (gen_done) begin
                gen <= 1'b0;
            end
            if (wr_en && wr_addr == reg_item_num) begin
                item_num <= wr_data[15:0];
            end
        end
    end

    // read data settles in the fetch cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (state == axil_read_fetch) begin
            case (rd_addr)
                reg_ctrl:     s_axi_rdata <= {{(word_w - 2){1'b0}}, run, gen};
                reg_item_num: s_axi_rdata <= {{(word_w - 16){1'b0}}, item_num};
                default:      s_axi_rdata <= '0;
            endcase
        end
    end

endmodule

// File: hdl/item_gen.sv
module item_gen #(
    parameter int DIM     = 256,
    parameter int ITEM_AW = 4
) (
    input  logic               AXIS_ACLK,
    input  logic               S_AXI_ARESETN,
    input  logic               gen,
    input  logic [15:0]        item_num,
    output logic               mem_we,
    output logic [ITEM_AW-1:0] mem_addr,
    output logic [DIM-1:0]     mem_vec,
    output logic [DIM-1:0]     tie_vec,
    output logic               gen_done
);
    import hdc_pkg::*;

    localparam int WORDS = DIM / word_w;
    localparam int WCW   = $clog2(WORDS);

    logic [word_w-1:0] xs_state;
    logic [word_w-1:0] xs_next;
    logic [WCW-1:0]    word_cnt;
    logic [15:0]       item_cnt;
    logic              vec_full;
    logic [DIM-1:0]    vec;

    function automatic logic [word_w-1:0] xorshift_step(input logic [word_w-1:0] x);
        logic [word_w-1:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    assign xs_next = xorshift_step(xs_state);

    // generator and word sequencing, all held at start while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            xs_state <= xorshift_seed;
            word_cnt <= '0;
            vec_full <= 1'b0;
            item_cnt <= '0;
        end else begin
            xs_state <= xs_next;
            vec_full <= (word_cnt == WCW'(WORDS - 1));
            if (word_cnt == WCW'(WORDS - 1)) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (vec_full) begin
                item_cnt <= item_cnt + 1'b1;
            end
        end
    end

    // word w of an item lands at bits 32w upward
    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            vec <= {xs_next, vec[DIM-1:word_w]};
        end
    end

    assign mem_we   = vec_full && (item_cnt < item_num);
    assign mem_addr = item_cnt[ITEM_AW-1:0];
    assign mem_vec  = vec;
    // the vector after the last item is the tie-break
    assign gen_done = gen && vec_full && (item_cnt == item_num);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            tie_vec <= '0;
        end else if (gen_done) begin
            tie_vec <= vec;
        end
    end

endmodule

// File: hdl/bundle_core.sv
module bundle_core #(
    parameter int DIM     = 256,
    parameter int ITEM_AW = 4,
    parameter int CNT_W   = 6
) (
    input  logic                        AXIS_ACLK,
    input  logic                        mem_we,
    input  logic [ITEM_AW-1:0]          mem_addr,
    input  logic [DIM-1:0]              mem_vec,
    input  logic [hdc_pkg::word_w-1:0]  lane_data,
    input  logic                        beat_v,
    input  logic                        clear,
    output logic [DIM*CNT_W-1:0]        count_vec
);

    logic [DIM-1:0]            item_mem [2**ITEM_AW];
    logic [DIM-1:0]            rd_vec;
    logic                      rd_v;
    logic [DIM-1:0][CNT_W-1:0] cnt;

    // ======================================================================
    // item memory, one read per accepted beat
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (mem_we) begin
            item_mem[mem_addr] <= mem_vec;
        end
        if (beat_v) begin
            rd_vec <= item_mem[lane_data[ITEM_AW-1:0]];
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        rd_v <= beat_v;
    end

    // ======================================================================
    // per-dimension counters
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        for (int d = 0; d < DIM; d++) begin
            if (clear) begin
                cnt[d] <= '0;
            end else if (rd_v && rd_vec[d]) begin
                cnt[d] <= cnt[d] + 1'b1;
            end
        end
    end

    assign count_vec = cnt;

endmodule

// File: hdl/majority_buffer.sv
module majority_buffer #(
    parameter int DIM       = 256,
    parameter int NUM_CORES = 2,
    parameter int CNT_W     = 6
) (
    input  logic                           AXIS_ACLK,
    input  logic [NUM_CORES*DIM*CNT_W-1:0] count_vec,
    input  logic [DIM-1:0]                 tie_vec,
    input  logic                           beat_v,
    input  logic                           capture,
    input  logic                           clear,
    output logic [DIM-1:0]                 result_vec
);

    localparam int SUM_W = CNT_W + $clog2(NUM_CORES) + 1;

    logic [CNT_W-1:0] beats;
    logic [SUM_W-1:0] n_total;
    logic [DIM-1:0]   maj;

    // a beat taken in the clear cycle belongs to the next frame
    always_ff @(posedge AXIS_ACLK) begin
        if (clear) begin
            beats <= CNT_W'(beat_v);
        end else if (beat_v) begin
            beats <= beats + 1'b1;
        end
    end

    // one count per beat and core
    assign n_total = SUM_W'(beats) * SUM_W'(NUM_CORES);

    always_comb begin
        logic [SUM_W-1:0] sum;
        for (int d = 0; d < DIM; d++) begin
            sum = '0;
            for (int c = 0; c < NUM_CORES; c++) begin
                sum = sum + SUM_W'(count_vec[(c * DIM + d) * CNT_W +: CNT_W]);
            end
            // twice the sum against N, tie-break on equality
            if ({sum, 1'b0} > n_total) begin
                maj[d] = 1'b1;
            end else if ({sum, 1'b0} == n_total) begin
                maj[d] = tie_vec[d];
            end else begin
                maj[d] = 1'b0;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (capture) begin
            result_vec <= maj;
        end
    end

endmodule

// File: hdl/frame_ctrl.sv
module frame_ctrl #(
    parameter int DIM = 256
) (
    input  logic                          AXIS_ACLK,
    input  logic                          S_AXI_ARESETN,
    input  logic                          run,
    input  logic                          gen,
    input  logic                          s_axis_tvalid,
    input  logic                          s_axis_tlast,
    input  logic                          m_axis_tready,
    input  logic [DIM-1:0]                result_vec,
    output logic                          s_axis_tready,
    output logic                          beat_v,
    output logic                          capture,
    output logic                          clear,
    output logic                          m_axis_tvalid,
    output logic                          m_axis_tlast,
    output logic [hdc_pkg::out_w-1:0]     m_axis_tdata,
    output logic [hdc_pkg::out_w/8-1:0]   m_axis_tstrb
);
    import hdc_pkg::*;

    localparam int SLICES = DIM / out_w;
    localparam int SW     = (SLICES > 1) ? $clog2(SLICES) : 1;

    frame_state_t  state;
    logic          drain_cnt;
    logic [SW-1:0] beat_sel;
    logic          last_hs;

    assign s_axis_tready = run && !gen && (state == frame_accept);
    assign beat_v        = s_axis_tvalid && s_axis_tready;
    assign capture       = state == frame_capture;

    // output serializer, slice 0 first
    assign m_axis_tvalid = state == frame_send;
    assign m_axis_tlast  = m_axis_tvalid && (beat_sel == SW'(SLICES - 1));
    assign m_axis_tdata  = result_vec[beat_sel * out_w +: out_w];
    assign m_axis_tstrb  = '1;
    assign last_hs       = m_axis_tlast && m_axis_tready;

    // ======================================================================
    // frame fsm
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= frame_accept;
            drain_cnt <= 1'b0;
            beat_sel  <= '0;
            // counters start from zero after reset
            clear     <= 1'b1;
        end else begin
            clear <= last_hs;
            case (state)
                frame_accept: begin
                    if (beat_v && s_axis_tlast) begin
                        state     <= frame_drain;
                        drain_cnt <= 1'b0;
                    end
                end
                // two cycles for memory read and add
                frame_drain: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        state <= frame_capture;
                    end
                end
                frame_capture: begin
                    state    <= frame_send;
                    beat_sel <= '0;
                end
                frame_send: begin
                    if (m_axis_tready) begin
                        if (m_axis_tlast) begin
                            state <= frame_accept;
                        end else begin
                            beat_sel <= beat_sel + 1'b1;
                        end
                    end
                end
                default: state <= frame_accept;
            endcase
        end
    end

endmodule

// File: hdl/hdc_top.sv
module hdc_top #(
    parameter int DIM       = 256,
    parameter int NUM_CORES = 2,
    parameter int ITEM_AW   = 4,
    parameter int CNT_W     = 6
) (
    input  logic                                    AXIS_ACLK,
    input  logic                                    S_AXI_ARESETN,
    input  logic [31:0]                             s_axi_awaddr,
    input  logic                                    s_axi_awvalid,
    output logic                                    s_axi_awready,
    input  logic [hdc_pkg::word_w-1:0]              s_axi_wdata,
    input  logic                                    s_axi_wvalid,
    output logic                                    s_axi_wready,
    output logic                                    s_axi_bvalid,
    output logic [1:0]                              s_axi_bresp,
    input  logic                                    s_axi_bready,
    input  logic [31:0]                             s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    output logic                                    s_axi_rvalid,
    output logic [hdc_pkg::word_w-1:0]              s_axi_rdata,
    output logic [1:0]                              s_axi_rresp,
    input  logic                                    s_axi_rready,
    input  logic [NUM_CORES*hdc_pkg::word_w-1:0]    s_axis_tdata,
    input  logic                                    s_axis_tvalid,
    output logic                                    s_axis_tready,
    input  logic                                    s_axis_tlast,
    output logic [hdc_pkg::out_w-1:0]               m_axis_tdata,
    output logic                                    m_axis_tvalid,
    input  logic                                    m_axis_tready,
    output logic                                    m_axis_tlast,
    output logic [hdc_pkg::out_w/8-1:0]             m_axis_tstrb
);
    import hdc_pkg::*;

    logic                           run;
    logic                           gen;
    logic [15:0]                    item_num;
    logic                           gen_done;
    logic                           mem_we;
    logic [ITEM_AW-1:0]             mem_addr;
    logic [DIM-1:0]                 mem_vec;
    logic [DIM-1:0]                 tie_vec;
    logic                           beat_v;
    logic                           capture;
    logic                           clear;
    logic [NUM_CORES*DIM*CNT_W-1:0] count_all;
    logic [DIM-1:0]                 result_vec;

    axil_regs u_regs (.*);

    item_gen #(.DIM(DIM), .ITEM_AW(ITEM_AW)) u_gen (.*);

    frame_ctrl #(.DIM(DIM)) u_frame (.*);

    majority_buffer #(.DIM(DIM), .NUM_CORES(NUM_CORES), .CNT_W(CNT_W)) u_maj (
        .AXIS_ACLK  (AXIS_ACLK),
        .count_vec  (count_all),
        .tie_vec    (tie_vec),
        .beat_v     (beat_v),
        .capture    (capture),
        .clear      (clear),
        .result_vec (result_vec)
    );

    // one core per 32-bit index lane
    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        bundle_core #(.DIM(DIM), .ITEM_AW(ITEM_AW), .CNT_W(CNT_W)) u_core (
            .AXIS_ACLK (AXIS_ACLK),
            .mem_we    (mem_we),
            .mem_addr  (mem_addr),
            .mem_vec   (mem_vec),
            .lane_data (s_axis_tdata[i * word_w +: word_w]),
            .beat_v    (beat_v),
            .clear     (clear),
            .count_vec (count_all[i * DIM * CNT_W +: DIM * CNT_W])
        );
    end

endmodule

// File: sim/tb_axil_tasks.svh
// error counters shared by all checks
int mismatch_cnt = 0;
int fail_cnt     = 0;

localparam int axil_timeout = 50;

// ======================================================================
// axi4-lite master tasks
// ======================================================================
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    bit aw_done;
    bit w_done;
    int t;
    aw_done = 0;
    w_done  = 0;
    t       = 0;
    @(posedge AXIS_ACLK);
    #1;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    while (!(aw_done && w_done) && t < axil_timeout) begin
        @(posedge AXIS_ACLK);
        if (s_axi_awvalid && s_axi_awready) aw_done = 1;
        if (s_axi_wvalid && s_axi_wready) w_done = 1;
        #1;
        if (aw_done) s_axi_awvalid = 1'b0;
        if (w_done) s_axi_wvalid = 1'b0;
        t++;
    end
    if (!(aw_done && w_done)) begin
        $display("timeout: write address or data was never accepted");
        fail_cnt++;
    end
    // response
    s_axi_bready = 1'b1;
    t = 0;
    @(posedge AXIS_ACLK);
    while (!s_axi_bvalid && t < axil_timeout) begin
        @(posedge AXIS_ACLK);
        t++;
    end
    if (!s_axi_bvalid) begin
        $display("timeout: no write response arrived");
        fail_cnt++;
    end else begin
        assert (s_axi_bresp == 2'b00) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: bresp is %b, not OKAY", $time, s_axi_bresp);
        end
    end
    #1 s_axi_bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    int t;
    t    = 0;
    data = '0;
    @(posedge AXIS_ACLK);
    #1;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(posedge AXIS_ACLK);
    while (!s_axi_arready && t < axil_timeout) begin
        @(posedge AXIS_ACLK);
        t++;
    end
    if (!s_axi_arready) begin
        $display("timeout: read address was never accepted");
        fail_cnt++;
    end
    #1;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    t = 0;
    @(posedge AXIS_ACLK);
    while (!s_axi_rvalid && t < axil_timeout) begin
        @(posedge AXIS_ACLK);
        t++;
    end
    if (!s_axi_rvalid) begin
        $display("timeout: no read data arrived");
        fail_cnt++;
    end else begin
        data = s_axi_rdata;
        assert (s_axi_rresp == 2'b00) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: rresp is %b, not OKAY", $time, s_axi_rresp);
        end
    end
    #1 s_axi_rready = 1'b0;
endtask

// File: sim/tb_hdc_top.sv
module tb_hdc_top;
    import hdc_pkg::*;

    localparam int DIM       = 256;
    localparam int NUM_CORES = 2;
    localparam int ITEM_AW   = 4;
    localparam int CNT_W     = 6;
    localparam int ITEMS     = 12;
    localparam int SLICES    = DIM / out_w;

    logic                          AXIS_ACLK;
    logic                          S_AXI_ARESETN;
    logic [31:0]                   s_axi_awaddr;
    logic                          s_axi_awvalid;
    logic                          s_axi_awready;
    logic [word_w-1:0]             s_axi_wdata;
    logic                          s_axi_wvalid;
    logic                          s_axi_wready;
    logic                          s_axi_bvalid;
    logic [1:0]                    s_axi_bresp;
    logic                          s_axi_bready;
    logic [31:0]                   s_axi_araddr;
    logic                          s_axi_arvalid;
    logic                          s_axi_arready;
    logic                          s_axi_rvalid;
    logic [word_w-1:0]             s_axi_rdata;
    logic [1:0]                    s_axi_rresp;
    logic                          s_axi_rready;
    logic [NUM_CORES*word_w-1:0]   s_axis_tdata;
    logic                          s_axis_tvalid;
    logic                          s_axis_tready;
    logic                          s_axis_tlast;
    logic [out_w-1:0]              m_axis_tdata;
    logic                          m_axis_tvalid;
    logic                          m_axis_tready;
    logic                          m_axis_tlast;
    logic [out_w/8-1:0]            m_axis_tstrb;

    int             seed = 32'h32a;
    logic [DIM-1:0] item_ref [0:ITEMS];
    int             idx0 [0:7];
    int             idx1 [0:7];
    logic           out_busy;
    logic [31:0]    rd;
    logic [31:0]    x;
    logic [DIM-1:0] got;
    int             t;
    int             a;
    int             b;

    `include "tb_axil_tasks.svh"

    hdc_top #(.DIM(DIM), .NUM_CORES(NUM_CORES), .ITEM_AW(ITEM_AW), .CNT_W(CNT_W)) uut (.*);

    always #10 AXIS_ACLK = ~AXIS_ACLK;

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [31:0] xorshift_next(input logic [31:0] v);
        logic [31:0] s;
        s = v ^ (v << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [DIM-1:0] majority_of(input int beats);
        logic [DIM-1:0] m;
        int ones;
        int n;
        n = beats * NUM_CORES;
        for (int d = 0; d < DIM; d++) begin
            ones = 0;
            for (int k = 0; k < beats; k++) begin
                if (item_ref[idx0[k]][d]) ones++;
                if (item_ref[idx1[k]][d]) ones++;
            end
            if (2 * ones > n) m[d] = 1'b1;
            else if (2 * ones == n) m[d] = item_ref[ITEMS][d];
            else m[d] = 1'b0;
        end
        return m;
    endfunction

    task automatic expect_value(input logic [DIM-1:0] v, input logic [DIM-1:0] exp,
                                input string what);
        assert (v === exp) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, v, exp);
        end
    endtask

    // ======================================================================
    // stream tasks
    // ======================================================================
    task automatic send_frame(input int beats);
        int tt;
        for (int k = 0; k < beats; k++) begin
            s_axis_tdata  = {32'(idx1[k]), 32'(idx0[k])};
            s_axis_tlast  = (k == beats - 1);
            s_axis_tvalid = 1'b1;
            tt = 0;
            @(posedge AXIS_ACLK);
            while (!s_axis_tready && tt < 200) begin
                @(posedge AXIS_ACLK);
                tt++;
            end
            if (!s_axis_tready) begin
                $display("timeout: input beat %0d was never accepted", k);
                fail_cnt++;
            end
            #1;
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    // random ready on the output side
    task automatic run_frame(input int beats, output logic [DIM-1:0] vec);
        logic [DIM-1:0] exp;
        bit took;
        int tt;
        exp = majority_of(beats);
        vec = '0;
        send_frame(beats);
        for (int s = 0; s < SLICES; s++) begin
            took = 0;
            tt   = 0;
            while (!took && tt < 200) begin
                @(posedge AXIS_ACLK);
                if (m_axis_tvalid && m_axis_tready) begin
                    took = 1;
                    vec[s*out_w +: out_w] = m_axis_tdata;
                    expect_value(m_axis_tdata, exp[s*out_w +: out_w], "output slice");
                    expect_value(m_axis_tlast, s == SLICES - 1, "output tlast");
                    expect_value(m_axis_tstrb, {(out_w/8){1'b1}}, "output tstrb");
                end
                #1 m_axis_tready = ($random(seed) & 1) == 1;
                tt++;
            end
            if (!took) begin
                $display("timeout: output slice %0d never came", s);
                fail_cnt++;
            end
        end
        m_axis_tready = 1'b0;
    endtask

    // busy from the input tlast until the output tlast
    always @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            out_busy <= 1'b0;
        end else if (s_axis_tvalid && s_axis_tready && s_axis_tlast) begin
            out_busy <= 1'b1;
        end else if (m_axis_tvalid && m_axis_tready && m_axis_tlast) begin
            out_busy <= 1'b0;
        end
    end

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: output moved under back-pressure", $time);
    end

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (out_busy || uut.gen) |-> !s_axis_tready)
    else begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: s_axis_tready high while busy or generating", $time);
    end

    // ======================================================================
    // stimulus
    // ======================================================================
    initial begin
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;

        // items 0..11, then the tie vector
        x = xorshift_seed;
        for (int k = 0; k <= ITEMS; k++) begin
            for (int w = 0; w < DIM / 32; w++) begin
                x = xorshift_next(x);
                item_ref[k][32*w +: 32] = x;
            end
        end

        repeat (10) @(posedge AXIS_ACLK);
        #1 S_AXI_ARESETN = 1'b1;

        axil_write(reg_item_num, 32'd12);
        axil_read(reg_item_num, rd);
        expect_value(rd, 12, "item_num readback");
        axil_read(32'h8, rd);
        expect_value(rd, 0, "unmapped read");

        // gen with run already set
        axil_write(reg_ctrl, 32'h3);
        rd = 32'h1;
        t  = 0;
        while (rd[0] && t < 100) begin
            axil_read(reg_ctrl, rd);
            t++;
        end
        if (rd[0]) begin
            $display("timeout: gen never cleared");
            fail_cnt++;
        end
        expect_value(rd, 2, "control readback");

        for (int k = 0; k < 3; k++) begin
            idx0[k] = {$random(seed)} % ITEMS;
            idx1[k] = {$random(seed)} % ITEMS;
        end
        run_frame(3, got);

        // same two different items twice, ties where they differ
        a = {$random(seed)} % ITEMS;
        b = (a + 1 + {$random(seed)} % (ITEMS - 1)) % ITEMS;
        for (int k = 0; k < 2; k++) begin
            idx0[k] = a;
            idx1[k] = b;
        end
        run_frame(2, got);
        expect_value(got & (item_ref[a] ^ item_ref[b]),
                     item_ref[ITEMS] & (item_ref[a] ^ item_ref[b]), "tied bits");

        // both lanes alike, a single core's odd count
        for (int k = 0; k < 3; k++) begin
            idx0[k] = {$random(seed)} % ITEMS;
            idx1[k] = idx0[k];
        end
        run_frame(3, got);

        axil_write(reg_ctrl, 32'h0);
        s_axis_tvalid = 1'b1;
        for (int k = 0; k < 40; k++) begin
            @(posedge AXIS_ACLK);
            assert (!s_axis_tready) else begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: s_axis_tready high with run cleared", $time);
            end
        end
        #1 s_axis_tvalid = 1'b0;

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+sim
hdl/hdc_pkg.sv
hdl/axil_regs.sv
hdl/item_gen.sv
hdl/bundle_core.sv
hdl/majority_buffer.sv
hdl/frame_ctrl.sv
hdl/hdc_top.sv
sim/tb_hdc_top.sv
